// File: verilog.f
memPkg.sv
sdpRam.sv
apbFront.sv
memIssue.sv
memTop.sv
memTb_assert.sv
memTb.sv

// File: Bender.yml
package:
  name: memsub

sources:
  - files:
      - memPkg.sv
      - sdpRam.sv
      - apbFront.sv
      - memIssue.sv
      - memTop.sv
  - target: test
    files:
      - memTb_assert.sv
      - memTb.sv

// File: memTb.sv
`timescale 1ns/1ps

module memTb;

  localparam int DataWidth  = memPkg::DefDataWidth;
  localparam int AddrWidth  = memPkg::DefPaddrWidth;
  localparam int WordBits   = memPkg::DefWordAddrWidth;
  localparam int StrbWidth  = DataWidth / 8;
  localparam int OffsetBits = $clog2(StrbWidth);
  localparam int Depth      = 1 << WordBits;
  localparam int WaitLimit  = 8;
  localparam int RandXfers  = 300;

  // one completed APB transfer as seen on the bus.
  typedef struct {
    logic [AddrWidth-1:0] addr;
    logic                 write;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strobes;
    logic [DataWidth-1:0] rdata;
    logic                 slvErr;
    int                   waits;
  } xferT;

  logic                 ClockA;
  logic                 rstN;
  logic [AddrWidth-1:0] paddr;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  logic [DataWidth-1:0] pwdata;
  logic [StrbWidth-1:0] pstrb;
  logic [DataWidth-1:0] prdata;
  logic                 pready;
  logic                 pslverr;

  logic [DataWidth-1:0] refMem [Depth];
  logic                 refValid [Depth]; // set once every byte of the word is known.
  logic [31:0]          lfsrState;
  xferT                 doneQ [$];
  int                   xferCount = 0;
  int                   checkCount = 0;

  memTop memTop_i (
    .ClockA(ClockA), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata),
    .pready(pready), .pslverr(pslverr)
  );

  bind apbFront memTb_assert protocolChecks_i (
    .ClockA(ClockA), .rstN(rstN), .psel(psel), .penable(penable), .pready(pready),
    .pslverr(pslverr), .op(op), .state(state)
  );

  initial
  begin
    ClockA = 1'b0;
    forever #5 ClockA = ~ClockA;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random bits and error exits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic nextBit();
    logic outBit;
    outBit    = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit)
      lfsrState = lfsrState ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1.
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++)
      value = {value[30:0], nextBit()};
    return value;
  endfunction

  task automatic stopRun();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
    $display("[ERROR] time %0t: %s expected 0x%h, got 0x%h", $time, name, expVal, gotVal);
    stopRun();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic void predictXfer(input xferT x, output logic [DataWidth-1:0] expData,
                                      output logic expErr, output logic dataKnown,
                                      output int expWaits);
    int   idx;
    logic inRange;
    idx       = x.addr[WordBits+OffsetBits-1:OffsetBits];
    inRange   = (x.addr[AddrWidth-1:WordBits+OffsetBits] == '0);
    expData   = '0; // errors and writes return zero.
    expErr    = !inRange;
    dataKnown = 1'b1;
    expWaits  = 0;
    if (inRange && x.write)
    begin
      for (int b = 0; b < StrbWidth; b++)
      begin
        if (x.strobes[b])
          refMem[idx][b*8 +: 8] = x.wdata[b*8 +: 8];
      end
      if (&x.strobes)
        refValid[idx] = 1'b1;
      dataKnown = 1'b0;
    end
    else if (inRange)
    begin
      expData   = refMem[idx];
      dataKnown = refValid[idx]; // never-written words are skipped.
      expWaits  = 1;
    end
  endfunction

  initial
  begin : compareProc
    xferT                 x;
    logic [DataWidth-1:0] expData;
    logic                 expErr;
    logic                 dataKnown;
    int                   expWaits;
    forever
    begin
      @(negedge ClockA);
      while (doneQ.size() > 0)
      begin
        x = doneQ.pop_front();
        predictXfer(x, expData, expErr, dataKnown, expWaits);
        checkCount++;
        assert (x.slvErr == expErr)
        else
          reportMismatch("pslverr", expErr, x.slvErr);
        if (dataKnown)
        begin
          assert (x.rdata == expData)
          else
            reportMismatch("prdata", expData, x.rdata);
        end
        assert (x.waits == expWaits)
        else
          reportMismatch("pready wait states", expWaits, x.waits);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB driver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic apbTransfer(input logic [AddrWidth-1:0] addr, input logic write,
                             input logic [DataWidth-1:0] data,
                             input logic [StrbWidth-1:0] strobes);
    xferT x;
    int   waits;
    @(negedge ClockA);
    psel    = 1'b1; // setup phase.
    penable = 1'b0;
    paddr   = addr;
    pwrite  = write;
    pwdata  = data;
    pstrb   = write ? strobes : '0;
    @(negedge ClockA);
    penable = 1'b1;
    waits   = 0;
    @(posedge ClockA);
    while (!pready)
    begin
      waits++;
      if (waits > WaitLimit)
      begin
        $display("pready did not rise within %0d access cycles at %0t", WaitLimit, $time);
        stopRun();
      end
      @(posedge ClockA);
    end
    x.addr    = addr;
    x.write   = write;
    x.wdata   = data;
    x.strobes = strobes;
    x.rdata   = prdata;
    x.slvErr  = pslverr;
    x.waits   = waits;
    doneQ.push_back(x);
    xferCount++;
  endtask

  task automatic apbIdle(input int cycles);
    repeat (cycles)
    begin
      @(negedge ClockA);
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic checkQuiet();
    assert (pready == 1'b0)
    else
      reportMismatch("pready", 0, pready);
    assert (pslverr == 1'b0)
    else
      reportMismatch("pslverr", 0, pslverr);
  endtask

  task automatic drainChecks();
    int cycles;
    cycles = 0;
    while (doneQ.size() != 0)
    begin
      cycles++;
      if (cycles > WaitLimit)
      begin
        $display("compare process still holds %0d transfers at %0t", doneQ.size(), $time);
        stopRun();
      end
      @(posedge ClockA);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial
  begin : mainProc
    logic [AddrWidth-1:0] addr;
    logic                 write;
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strobes;
    int                   assertFails;
    lfsrState = 32'he16e18f6;
    rstN      = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pstrb     = '0;
    for (int i = 0; i < Depth; i++)
      refValid[i] = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      @(negedge ClockA);
      checkQuiet();
    end
    rstN = 1'b1;
    for (int i = 0; i < 3; i++)
    begin
      @(posedge ClockA);
      checkQuiet(); // no transfer yet.
    end

    // full words, then partial merges into words 0 to 3.
    for (int w = 0; w < 8; w++)
      apbTransfer(AddrWidth'(w * 4), 1'b1, randBits(32), '1);
    for (int w = 0; w < 8; w++)
      apbTransfer(AddrWidth'(w * 4), 1'b0, '0, '0);
    apbTransfer(12'h000, 1'b1, 32'hA1B2C3D4, 4'b0001);
    apbTransfer(12'h004, 1'b1, 32'h55667788, 4'b0110);
    apbTransfer(12'h008, 1'b1, 32'hDEADBEEF, 4'b1010);
    apbTransfer(12'h00C, 1'b1, 32'h0BADF00D, 4'b1000);
    for (int w = 0; w < 4; w++)
      apbTransfer(AddrWidth'(w * 4), 1'b0, '0, '0);
    apbIdle(2);

    // addresses above the RAM alias word 1 and word 2 in their low bits.
    apbTransfer(12'h404, 1'b1, 32'hFFFFFFFF, '1);
    apbTransfer(12'hC08, 1'b0, '0, '0);
    apbTransfer(12'h004, 1'b0, '0, '0);
    apbTransfer(12'h008, 1'b0, '0, '0);
    apbIdle(2);

    for (int n = 0; n < RandXfers; n++)
    begin
      addr = '0;
      addr[WordBits+OffsetBits-1:0] =
        (WordBits+OffsetBits)'(randBits(5 + OffsetBits)); // 32 words keep reads on hits.
      if (randBits(3) == 0)
        addr[AddrWidth-1:WordBits+OffsetBits] =
          (AddrWidth-WordBits-OffsetBits)'(randBits(2) | 1);
      write   = 1'(randBits(1));
      data    = randBits(32);
      strobes = randBits(1) ? '1 : StrbWidth'(randBits(StrbWidth));
      apbTransfer(addr, write, data, strobes);
    end
    apbIdle(2);
    drainChecks();

    assertFails = memTop_i.apbFront_i.protocolChecks_i.failCount;
    if (checkCount == xferCount && assertFails == 0)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
    begin
      $display("%0d of %0d transfers checked, %0d protocol assertion failures",
               checkCount, xferCount, assertFails);
      $display("FAIL: see errors above");
      $fatal(1, "run ended with failures");
    end
  end

endmodule

// File: memTb_assert.sv
`timescale 1ns/1ps

module memTb_assert (
  input logic             ClockA,
  input logic             rstN,
  input logic             psel,
  input logic             penable,
  input logic             pready,
  input logic             pslverr,
  input memPkg::memOpE    op,
  input memPkg::apbPhaseE state
);

  int failCount = 0; // number of failed protocol checks.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB slave protocol
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  readyInAccess: assert property (@(posedge ClockA) disable iff (!rstN)
    pready |-> (psel && penable))
  else
  begin
    failCount++;
    $error("pready is high outside an access cycle");
  end

  // an error ends its transfer in the first access cycle.
  errorWithReady: assert property (@(posedge ClockA) disable iff (!rstN)
    pslverr |-> (pready && $past(psel && !penable)))
  else
  begin
    failCount++;
    $error("pslverr is high outside the first access cycle of a transfer");
  end

  // a request leaves the front end once, in the first access cycle.
  opInAccess: assert property (@(posedge ClockA) disable iff (!rstN)
    (op != memPkg::opNone) |-> $past(psel && !penable)
      ##1 ((op == memPkg::opNone) && (state != memPkg::phAccess)))
  else
  begin
    failCount++;
    $error("a RAM request was issued outside the first access cycle, or twice");
  end

endmodule

// File: memTop.sv
`timescale 1ns/1ps

module memTop #(
  parameter int DataWidth     = memPkg::DefDataWidth,
  parameter int WordAddrWidth = memPkg::DefWordAddrWidth,
  parameter int PaddrWidth    = memPkg::DefPaddrWidth
) (
  input  logic                   ClockA,
  input  logic                   rstN,
  input  logic [PaddrWidth-1:0]  paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [DataWidth-1:0]   pwdata,
  input  logic [DataWidth/8-1:0] pstrb,
  output logic [DataWidth-1:0]   prdata,
  output logic                   pready,
  output logic                   pslverr
);

  // front end to issue stage.
  memPkg::memOpE              op;
  logic [WordAddrWidth-1:0]   wordAddr;
  logic [DataWidth-1:0]       wrData;
  logic [DataWidth/8-1:0]     strb;
  logic [DataWidth-1:0]       rdData;

  // issue stage to RAM.
  logic [WordAddrWidth-1:0]   raddr;
  logic                       re;
  logic [WordAddrWidth-1:0]   waddr;
  logic [DataWidth-1:0]       wdata;
  logic [DataWidth-1:0]       mask;
  logic                       we;
  logic [DataWidth-1:0]       rdata;

  apbFront #(
    .DataWidth(DataWidth), .WordAddrWidth(WordAddrWidth), .PaddrWidth(PaddrWidth)
  ) apbFront_i (
    .ClockA(ClockA), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb), .rdData(rdData),
    .prdata(prdata), .pready(pready), .pslverr(pslverr), .op(op),
    .wordAddr(wordAddr), .wrData(wrData), .strb(strb)
  );

  memIssue #(.DataWidth(DataWidth), .WordAddrWidth(WordAddrWidth)) memIssue_i (
    .ClockA(ClockA), .rstN(rstN), .op(op), .wordAddr(wordAddr), .wrData(wrData),
    .strb(strb), .rdata(rdata), .rdData(rdData), .raddr(raddr), .re(re),
    .waddr(waddr), .wdata(wdata), .mask(mask), .we(we)
  );

  sdpRam #(.DataWidth(DataWidth), .WordAddrWidth(WordAddrWidth)) sdpRam_i (
    .ClockA(ClockA), .raddr(raddr), .re(re), .waddr(waddr), .wdata(wdata),
    .mask(mask), .we(we), .rdata(rdata)
  );

endmodule

// File: memIssue.sv
`timescale 1ns/1ps

module memIssue #(
  parameter int DataWidth     = 32,
  parameter int WordAddrWidth = 8
) (
  input  logic                     ClockA,
  input  logic                     rstN,
  input  memPkg::memOpE            op,
  input  logic [WordAddrWidth-1:0] wordAddr,
  input  logic [DataWidth-1:0]     wrData,
  input  logic [DataWidth/8-1:0]   strb,
  input  logic [DataWidth-1:0]     rdata,
  output logic [DataWidth-1:0]     rdData,
  output logic [WordAddrWidth-1:0] raddr,
  output logic                     re,
  output logic [WordAddrWidth-1:0] waddr,
  output logic [DataWidth-1:0]     wdata,
  output logic [DataWidth-1:0]     mask,
  output logic                     we
);

  localparam int StrbWidth = DataWidth / 8;

  logic                 readPend; // RAM output carries a fresh word.
  logic [DataWidth-1:0] rdHold;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // RAM port strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign re    = (op == memPkg::opRead);
  assign we    = (op == memPkg::opWrite);
  assign raddr = wordAddr;
  assign waddr = wordAddr;
  assign wdata = wrData;

  // each byte strobe covers eight mask bits.
  always_comb
  begin
    for (int i = 0; i < StrbWidth; i++)
    begin
      mask[i*8 +: 8] = {8{strb[i]}};
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read return
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge ClockA or negedge rstN)
  begin
    if (!rstN)
      readPend <= 1'b0;
    else
      readPend <= re;
  end

  always_ff @(posedge ClockA)
  begin
    if (readPend)
      rdHold <= rdata;
  end

  // the fresh word goes straight out, and the copy holds it afterwards.
  assign rdData = readPend ? rdata : rdHold;

endmodule

// File: apbFront.sv
`timescale 1ns/1ps

module apbFront #(
  parameter int DataWidth     = 32,
  parameter int WordAddrWidth = 8,
  parameter int PaddrWidth    = 12
) (
  input  logic                     ClockA,
  input  logic                     rstN,
  input  logic [PaddrWidth-1:0]    paddr,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [DataWidth-1:0]     pwdata,
  input  logic [DataWidth/8-1:0]   pstrb,
  input  logic [DataWidth-1:0]     rdData,
  output logic [DataWidth-1:0]     prdata,
  output logic                     pready,
  output logic                     pslverr,
  output memPkg::memOpE            op,
  output logic [WordAddrWidth-1:0] wordAddr,
  output logic [DataWidth-1:0]     wrData,
  output logic [DataWidth/8-1:0]   strb
);

  localparam int StrbWidth  = DataWidth / 8;
  localparam int OffsetBits = $clog2(StrbWidth);

  memPkg::apbPhaseE state;
  memPkg::apbPhaseE stateNext;
  logic             accessCycle;
  logic             inRange;

  assign accessCycle = (state == memPkg::phAccess) && psel && penable;
  assign inRange     = (paddr[PaddrWidth-1:WordAddrWidth+OffsetBits] == '0);

  assign wordAddr = paddr[WordAddrWidth+OffsetBits-1:OffsetBits];
  assign wrData   = pwdata;
  assign strb     = pstrb;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transfer phase
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb
  begin
    stateNext = state;
    case (state)
      memPkg::phIdle:   if (psel && !penable) stateNext = memPkg::phAccess;
      memPkg::phAccess:
      begin
        if (accessCycle)
          stateNext = (op == memPkg::opRead) ? memPkg::phWait : memPkg::phIdle;
        else if (!psel)
          stateNext = memPkg::phIdle; // master dropped the transfer.
      end
      default:          stateNext = memPkg::phIdle;
    endcase
  end

  always_ff @(posedge ClockA or negedge rstN)
  begin
    if (!rstN)
      state <= memPkg::phIdle;
    else
      state <= stateNext;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request and response
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // one op per transfer, and none for an address outside the RAM.
  always_comb
  begin
    op = memPkg::opNone;
    if (accessCycle && inRange)
      op = pwrite ? memPkg::opWrite : memPkg::opRead;
  end

  // writes and errors finish at once. reads finish in phWait.
  assign pready  = (accessCycle && (pwrite || !inRange)) || (state == memPkg::phWait);
  assign pslverr = accessCycle && !inRange;
  assign prdata  = (state == memPkg::phWait) ? rdData : '0;

endmodule

// File: sdpRam.sv
`timescale 1ns/1ps

module sdpRam #(
  parameter int DataWidth     = 32,
  parameter int WordAddrWidth = 8
) (
  input  logic                     ClockA,
  input  logic [WordAddrWidth-1:0] raddr,
  input  logic                     re,
  input  logic [WordAddrWidth-1:0] waddr,
  input  logic [DataWidth-1:0]     wdata,
  input  logic [DataWidth-1:0]     mask,
  input  logic                     we,
  output logic [DataWidth-1:0]     rdata
);

  localparam int Depth = 1 << WordAddrWidth;

  logic [DataWidth-1:0] memArray [Depth];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // only bits with a set mask bit take the new value.
  always_ff @(posedge ClockA)
  begin
    if (we)
    begin
      memArray[waddr] <= (memArray[waddr] & ~mask) | (wdata & mask);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge ClockA)
  begin
    if (re)
    begin
      rdata <= memArray[raddr]; // a same-address write returns old data.
    end
  end

endmodule

// File: memPkg.sv
package memPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // default sizes for the memory subsystem
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int DefDataWidth     = 32; // one RAM word.
  localparam int DefWordAddrWidth = 8;  // 256 words.
  localparam int DefPaddrWidth    = 12; // APB byte address.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state and opcode encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // phase of the APB slave. phWait is the extra cycle of a read.
  typedef enum logic [1:0] {
    phIdle   = 2'd0,
    phAccess = 2'd1,
    phWait   = 2'd2
  } apbPhaseE;

  // request handed from the APB front end to the issue stage.
  typedef enum logic [1:0] {
    opNone  = 2'd0,
    opRead  = 2'd1,
    opWrite = 2'd2
  } memOpE;

endpackage
